/* verif/sdmacVectors.txt */
# Cmd and hex args: W reg data, R reg expect, B count firstByte, F, I level, N intN_o,
# M address word, D cycles, H grantHoldCycles, E testNumber. Reg is address bits 6:2
R 07 00000004
E 1
W 02 00000004
R 02 00000004
W 03 12345678
R 03 12345678
E 2
W 03 00001000
W 04 00000000
B 10 00
M 1000 00010203
M 1004 04050607
M 1008 08090a0b
M 100c 0c0d0e0f
W 0f 00000000
E 3
W 02 00000004
W 03 00002000
W 04 00000000
B 06 a0
F
M 2000 a0a1a2a3
M 2004 a4a50000
D 8
R 07 00000007
N 0
W 0f 00000000
E 4
W 02 00000000
W 03 00003000
H 80
W 04 00000000
B 14 40
D 50
R 07 00000408
M 3000 40414243
M 3004 44454647
M 3008 48494a4b
M 300c 4c4d4e4f
M 3010 50515253
W 0f 00000000
E 5
I 1
D 2
N 1
R 07 00000015
W 02 00000004
N 0
I 0
D 2
N 1
R 07 00000004
W 02 00000000
E 6

/* sdmacTop.f */
verilog/sdmacPkg.sv
verilog/sdmacRegisters.sv
verilog/sdmacFifo.sv
verilog/scsiStateMachine.sv
verilog/cpuStateMachine.sv
verilog/sdmacTop.sv
verif/sdmacTop_properties.sv
verif/sdmacTb.sv

/* verif/sdmacTb.sv */
// SDMAC testbench: vector driven register, transfer, flush, back-pressure and interrupt tests
`timescale 1ns/10ps
`default_nettype none

module sdmacTb;
    import sdmacPkg::*;

    localparam int FIFO_DEPTH = 4;          // Small queue so back-pressure is reached quickly
    localparam int CLK_PERIOD = 20;

    logic        QnCPUCLK;
    logic        arstN;
    cpuReqT      cpuReq;
    logic        scsiIntReq;
    logic        dreqN;
    logic [7:0]  pd;
    logic        bgN;
    logic        dsackN;
    wire  [31:0] rdata;
    wire         regAck;
    wire         intN;
    wire         dackN;
    wire         iorN;
    wire         brN;
    wire         bgackN;
    wire         asN;
    wire         dsN;
    wire         rwN;
    wire  [31:0] addr;
    wire  [31:0] data;

    logic [31:0] hostMem [logic [31:0]];    // Host memory, written by the bus model
    logic [7:0]  byteQ [$];                 // Bytes still offered by the SCSI chip
    logic [31:0] lcgState = 32'he69650af;
    int          holdLeft = 0;
    int          lineCount = 0;
    int          testErrors = 0;
    int          totalErrors = 0;
    int          testCount = 0;
    int          bytesTaken = 0;
    int          wordsWritten = 0;

    sdmacTop #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) UUT (
        .QnCPUCLK     (QnCPUCLK),
        .arstN_i      (arstN),
        .cpuReq_i     (cpuReq),
        .rdata_o      (rdata),
        .regAck_o     (regAck),
        .intN_o       (intN),
        .scsiIntReq_i (scsiIntReq),
        .dreqN_i      (dreqN),
        .pd_i         (pd),
        .dackN_o      (dackN),
        .iorN_o       (iorN),
        .brN_o        (brN),
        .bgN_i        (bgN),
        .bgackN_o     (bgackN),
        .asN_o        (asN),
        .dsN_o        (dsN),
        .rwN_o        (rwN),
        .dsackN_i     (dsackN),
        .addr_o       (addr),
        .data_o       (data)
    );

    initial begin
        QnCPUCLK = 1'b0;
        forever #(CLK_PERIOD / 2) QnCPUCLK = ~QnCPUCLK;
    end

    function automatic logic [31:0] nextRand();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    // Everything is driven and sampled 1 ns after the rising edge
    task automatic tick();
        @(posedge QnCPUCLK);
        #1;
    endtask

    task automatic regAccess(input logic wr, input logic [4:0] a, input logic [31:0] d,
                             output logic [31:0] rd);
        cpuReq = '{valid: 1'b1, write: wr, addr: regAddrT'(a), wdata: d};
        tick();
        cpuReq = '0;
        assert (regAck == 1'b1) else begin
            $display("error: regAck_o exp 1 got %h", regAck);
            testErrors++;
        end
        rd = rdata;
    endtask

    // SCSI chip: DREQ while bytes wait, next byte on the bus for each DACK
    initial begin
        logic dackPrev;
        dackPrev = 1'b1;
        forever begin
            tick();
            if (dackPrev && !dackN) begin
                pd = byteQ.pop_front();
                bytesTaken++;
                assert (bytesTaken - 4 * wordsWritten <= 4 * FIFO_DEPTH) else begin
                    $display("byte taken although the FIFO had no room for it");
                    testErrors++;
                end
            end
            dreqN    = (byteQ.size() == 0);
            dackPrev = dackN;
        end
    end

    // Host side: arbiter with random grant delay, memory with random DSACK delay
    initial begin
        int grantWait;
        int grantDelay;
        int ackWait;
        int ackDelay;
        grantWait  = 0;
        grantDelay = 0;
        ackWait    = 0;
        ackDelay   = 1;
        forever begin
            tick();
            if (holdLeft > 0) holdLeft--;
            if (!bgackN) begin
                bgN = 1'b1;                 // Grant withdrawn once the bus is taken
            end else if (!brN && bgN) begin
                if (grantWait >= grantDelay && holdLeft == 0) begin
                    bgN        = 1'b0;
                    grantWait  = 0;
                    grantDelay = nextRand() >> 29;
                end else begin
                    grantWait++;
                end
            end
            if (!dsackN) begin
                dsackN = 1'b1;
            end else if (!asN) begin
                if (ackWait >= ackDelay) begin
                    assert (rwN == 1'b0) else begin
                        $display("error: rwN_o exp 0 got %h", rwN);
                        testErrors++;
                    end
                    assert (dsN == 1'b0) else begin
                        $display("error: dsN_o exp 0 got %h", dsN);
                        testErrors++;
                    end
                    hostMem[addr] = data;
                    wordsWritten++;
                    dsackN   = 1'b0;
                    ackWait  = 0;
                    ackDelay = 1 + (nextRand() >> 30) % 3;
                end else begin
                    ackWait++;
                end
            end
        end
    end

    initial begin
        wait (lineCount > 0);
        repeat (lineCount * 200 + 20) @(posedge QnCPUCLK);
        $display("watchdog expired, a transfer or handshake never completed");
        $display("Done: errors found");
        $finish;
    end

    initial begin
        int          fd;
        int          lines;
        string       line;
        logic [7:0]  cmd;
        logic [31:0] arg1;
        logic [31:0] arg2;
        logic [31:0] rd;
        arstN      = 1'b0;
        cpuReq     = '0;
        scsiIntReq = 1'b0;
        dreqN      = 1'b1;
        pd         = 8'h00;
        bgN        = 1'b1;
        dsackN     = 1'b1;
        lines      = 0;
        fd = $fopen("verif/sdmacVectors.txt", "r");
        if (fd == 0) begin
            $display("cannot open the vector file verif/sdmacVectors.txt");
            $display("Done: errors found");
            $finish;
        end else begin
            while ($fgets(line, fd)) lines++;
            $fclose(fd);
            lineCount = lines;
            fd = $fopen("verif/sdmacVectors.txt", "r");
            repeat (10) tick();
            assert ({regAck, dackN, iorN, brN, bgackN, asN, dsN, intN} == 8'h7f) else begin
                $display("error: reset outputs %s exp 7f got %h",
                         "{regAck_o,dackN_o,iorN_o,brN_o,bgackN_o,asN_o,dsN_o,intN_o}",
                         {regAck, dackN, iorN, brN, bgackN, asN, dsN, intN});
                testErrors++;
            end
            arstN = 1'b1;
            while ($fgets(line, fd)) begin
                cmd  = "#";
                arg1 = '0;
                arg2 = '0;
                void'($sscanf(line, "%c %h %h", cmd, arg1, arg2));
                case (cmd)
                    "W": regAccess(1'b1, arg1[4:0], arg2, rd);
                    "R": begin
                        regAccess(1'b0, arg1[4:0], 32'h0, rd);
                        assert (rd == arg2) else begin
                            $display("error: rdata_o reg %h exp %h got %h", arg1[4:0], arg2, rd);
                            testErrors++;
                        end
                    end
                    "B": for (int i = 0; i < arg1; i++) byteQ.push_back(8'(arg2 + i));
                    "F": begin
                        while (byteQ.size() != 0 || !dackN) tick();   // Last byte latched
                        regAccess(1'b1, ADDR_FLUSH, 32'h0, rd);
                    end
                    "I": scsiIntReq = arg1[0];
                    "N": assert (intN == arg1[0]) else begin
                        $display("error: intN_o exp %h got %h", arg1[0], intN);
                        testErrors++;
                    end
                    "M": begin
                        while (!hostMem.exists(arg1)) tick();
                        assert (hostMem[arg1] == arg2) else begin
                            $display("error: data_o at %h exp %h got %h", arg1, arg2,
                                     hostMem[arg1]);
                            testErrors++;
                        end
                    end
                    "D": repeat (arg1) tick();
                    "H": holdLeft = arg1;
                    "E": begin
                        $display("test %0d %s, %0d errors", arg1,
                                 (testErrors == 0) ? "passed" : "failed", testErrors);
                        totalErrors += testErrors;
                        testErrors = 0;
                        testCount++;
                        // Every test drains fully, so byte accounting restarts here
                        bytesTaken   = 0;
                        wordsWritten = 0;
                    end
                    default: ;
                endcase
            end
            $fclose(fd);
            totalErrors += testErrors;
            assert (UUT.uProps.failCount == 0) else begin
                $display("bus or peripheral handshake properties failed %0d times",
                         UUT.uProps.failCount);
                totalErrors++;
            end
            $display("%0d tests run, %0d errors", testCount, totalErrors);
            if (totalErrors == 0) begin
                $display("Done: no errors");
            end else begin
                $display("Done: errors found");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

/* verif/sdmacTop_properties.sv */
// SDMAC handshake checks on bus arbitration, bus strobes and SCSI DMA strobes
`timescale 1ns/10ps
`default_nettype none

module sdmacTopProperties (
    input wire QnCPUCLK,
    input wire arstN_i,
    input wire bgN_i,
    input wire bgackN_o,
    input wire asN_o,
    input wire dackN_o,
    input wire iorN_o
);
    int failCount = 0;

    // Bus is taken only after a grant
    assert property (@(posedge QnCPUCLK) disable iff (!arstN_i)
        $fell(bgackN_o) |-> $past(!bgN_i))
        else begin
            $error("BGACK asserted without a preceding bus grant");
            failCount++;
        end

    assert property (@(posedge QnCPUCLK) disable iff (!arstN_i) !asN_o |-> !bgackN_o)
        else begin
            $error("AS asserted while the bus is not owned");
            failCount++;
        end

    // DACK and IOR form one strobe, low for exactly the two strobe cycles
    assert property (@(posedge QnCPUCLK) disable iff (!arstN_i)
        ($fell(dackN_o) || $fell(iorN_o)) |->
            ($fell(dackN_o) && $fell(iorN_o)) ##1 (!dackN_o && !iorN_o)
            ##1 (dackN_o && iorN_o))
        else begin
            $error("DACK and IOR did not fall together or were not low for two cycles");
            failCount++;
        end

endmodule

bind sdmacTop sdmacTopProperties uProps (.*);

`default_nettype wire

/* verilog/sdmacTop.sv */
// SDMAC top level: register block, byte FIFO, SCSI engine and host bus master
`timescale 1ns/10ps
`default_nettype none

module sdmacTop #(
    parameter int FIFO_DEPTH = 8
) (
    input  wire                          QnCPUCLK,
    input  wire                          arstN_i,
    // CPU register port
    input  wire sdmacPkg::cpuReqT        cpuReq_i,
    output wire [31:0]                   rdata_o,
    output wire                          regAck_o,
    output wire                          intN_o,
    // SCSI chip side
    input  wire                          scsiIntReq_i,
    input  wire                          dreqN_i,
    input  wire [7:0]                    pd_i,
    output wire                          dackN_o,
    output wire                          iorN_o,
    // Host bus side
    output wire                          brN_o,
    input  wire                          bgN_i,
    output wire                          bgackN_o,
    output wire                          asN_o,
    output wire                          dsN_o,
    output wire                          rwN_o,
    input  wire                          dsackN_i,
    output wire [sdmacPkg::ADDR_W-1:0]   addr_o,
    output wire [31:0]                   data_o
);
    import sdmacPkg::*;

    wire dmaCtrlT  dmaCtrl;
    wire fifoStatT fifoStat;
    wire           push;
    wire [7:0]     pushByte;
    wire           pop;
    wire [31:0]    head;

    sdmacRegisters uRegisters (
        .QnCPUCLK     (QnCPUCLK),
        .arstN_i      (arstN_i),
        .cpuReq_i     (cpuReq_i),
        .fifoStat_i   (fifoStat),
        .scsiIntReq_i (scsiIntReq_i),
        .dmaCtrl_o    (dmaCtrl),
        .rdata_o      (rdata_o),
        .regAck_o     (regAck_o),
        .intN_o       (intN_o)
    );

    sdmacFifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) uFifo (
        .QnCPUCLK   (QnCPUCLK),
        .arstN_i    (arstN_i),
        .push_i     (push),
        .pushByte_i (pushByte),
        .pop_i      (pop),
        .flush_i    (dmaCtrl.flushReq),
        .start_i    (dmaCtrl.dmaEna),
        .head_o     (head),
        .fifoStat_o (fifoStat)
    );

    scsiStateMachine uScsiSm (
        .QnCPUCLK   (QnCPUCLK),
        .arstN_i    (arstN_i),
        .dmaCtrl_i  (dmaCtrl),
        .fifoFull_i (fifoStat.full),
        .dreqN_i    (dreqN_i),
        .pd_i       (pd_i),
        .dackN_o    (dackN_o),
        .iorN_o     (iorN_o),
        .push_o     (push),
        .pushByte_o (pushByte)
    );

    cpuStateMachine uCpuSm (
        .QnCPUCLK    (QnCPUCLK),
        .arstN_i     (arstN_i),
        .dmaCtrl_i   (dmaCtrl),
        .fifoEmpty_i (fifoStat.empty),
        .head_i      (head),
        .bgN_i       (bgN_i),
        .dsackN_i    (dsackN_i),
        .pop_o       (pop),
        .brN_o       (brN_o),
        .bgackN_o    (bgackN_o),
        .asN_o       (asN_o),
        .dsN_o       (dsN_o),
        .rwN_o       (rwN_o),
        .addr_o      (addr_o),
        .data_o      (data_o)
    );

endmodule

`default_nettype wire

/* verilog/cpuStateMachine.sv */
// Host bus master: arbitrates with BR/BG/BGACK and writes queued longwords to memory
`timescale 1ns/10ps
`default_nettype none

module cpuStateMachine (
    input  wire                          QnCPUCLK,
    input  wire                          arstN_i,
    input  wire sdmacPkg::dmaCtrlT       dmaCtrl_i,
    input  wire                          fifoEmpty_i,
    input  wire [31:0]                   head_i,
    input  wire                          bgN_i,
    input  wire                          dsackN_i,
    output logic                         pop_o,
    output logic                         brN_o,
    output logic                         bgackN_o,
    output logic                         asN_o,
    output logic                         dsN_o,
    output logic                         rwN_o,
    output logic [sdmacPkg::ADDR_W-1:0]  addr_o,     // Also the address counter
    output logic [31:0]                  data_o
);
    import sdmacPkg::*;

    cpuStateT state;
    logic     dmaEnaQ;
    logic     haveWork;

    assign haveWork = dmaCtrl_i.dmaEna & ~fifoEmpty_i;

    always_ff @(posedge QnCPUCLK or negedge arstN_i) begin
        if (!arstN_i) begin
            state    <= CPU_IDLE;
            brN_o    <= 1'b1;
            bgackN_o <= 1'b1;
            asN_o    <= 1'b1;
            dsN_o    <= 1'b1;
            rwN_o    <= 1'b1;
            pop_o    <= 1'b0;
            addr_o   <= '0;
            dmaEnaQ  <= 1'b0;
        end else begin
            dmaEnaQ <= dmaCtrl_i.dmaEna;
            pop_o   <= 1'b0;
            // New transfer reloads the counter from the start address
            if (dmaCtrl_i.dmaEna && !dmaEnaQ) addr_o <= dmaCtrl_i.startAddr;
            case (state)
                CPU_IDLE: begin
                    if (haveWork) begin
                        brN_o <= 1'b0;
                        state <= CPU_REQUEST;
                    end
                end
                CPU_REQUEST: begin
                    if (!bgN_i) begin
                        brN_o    <= 1'b1;
                        bgackN_o <= 1'b0;
                        rwN_o    <= 1'b0;       // Write only
                        state    <= CPU_OWN;
                    end
                end
                CPU_OWN: begin
                    // Keep the bus while words remain, else hand it back
                    if (haveWork) begin
                        asN_o <= 1'b0;
                        dsN_o <= 1'b0;
                        state <= CPU_STROBE;
                    end else begin
                        bgackN_o <= 1'b1;
                        rwN_o    <= 1'b1;
                        state    <= CPU_IDLE;
                    end
                end
                CPU_STROBE: begin
                    if (!dsackN_i) begin
                        asN_o  <= 1'b1;
                        dsN_o  <= 1'b1;
                        pop_o  <= 1'b1;
                        addr_o <= addr_o + ADDR_W'(4);
                        state  <= CPU_RELEASE;
                    end
                end
                CPU_RELEASE: state <= CPU_OWN;  // Lets the pop reach the FIFO flags
                default:     state <= CPU_IDLE;
            endcase
        end
    end

    // Head word is held for the whole strobe
    always_ff @(posedge QnCPUCLK) begin
        if (state == CPU_OWN) data_o <= head_i;
    end

endmodule

`default_nettype wire

/* verilog/scsiStateMachine.sv */
// SCSI side DMA engine: answers DREQ with DACK/IOR and hands each byte to the FIFO
`timescale 1ns/10ps
`default_nettype none

module scsiStateMachine (
    input  wire                   QnCPUCLK,
    input  wire                   arstN_i,
    input  wire sdmacPkg::dmaCtrlT dmaCtrl_i,
    input  wire                   fifoFull_i,
    input  wire                   dreqN_i,
    input  wire [7:0]             pd_i,
    output logic                  dackN_o,
    output logic                  iorN_o,
    output logic                  push_o,
    output logic [7:0]            pushByte_o
);
    import sdmacPkg::*;

    scsiStateT state;
    scsiStateT nextState;
    logic      strobeN;        // Drives both DACK and IOR
    logic      startCycle;

    // A full FIFO leaves DREQ pending, the byte is taken later
    assign startCycle = dmaCtrl_i.dmaEna & ~fifoFull_i & ~dreqN_i;

    always_comb begin
        nextState = state;
        case (state)
            SCSI_IDLE: begin
                if (startCycle) nextState = SCSI_STROBE1;
            end
            SCSI_STROBE1: nextState = SCSI_STROBE2;
            SCSI_STROBE2: nextState = SCSI_LATCH;
            SCSI_LATCH:   nextState = SCSI_IDLE;
            default:      nextState = SCSI_IDLE;
        endcase
    end

    always_ff @(posedge QnCPUCLK or negedge arstN_i) begin
        if (!arstN_i) begin
            state   <= SCSI_IDLE;
            strobeN <= 1'b1;
        end else begin
            state   <= nextState;
            strobeN <= ~((nextState == SCSI_STROBE1) || (nextState == SCSI_STROBE2));
        end
    end

    // Byte is captured on the edge into LATCH, while the strobes are still low
    always_ff @(posedge QnCPUCLK) begin
        if (state == SCSI_STROBE2) pushByte_o <= pd_i;
    end

    assign push_o  = (state == SCSI_LATCH);   // One cycle per byte
    assign dackN_o = strobeN;
    assign iorN_o  = strobeN;

endmodule

`default_nettype wire

/* verilog/sdmacFifo.sv */
// SDMAC longword FIFO: packs bytes big-endian, queues longwords, pads on flush
`timescale 1ns/10ps
`default_nettype none

module sdmacFifo #(
    parameter int FIFO_DEPTH = 8
) (
    input  wire                  QnCPUCLK,
    input  wire                  arstN_i,
    input  wire                  push_i,
    input  wire [7:0]            pushByte_i,
    input  wire                  pop_i,
    input  wire                  flush_i,
    input  wire                  start_i,      // DMA enable, rising edge starts a transfer
    output logic [31:0]          head_o,
    output sdmacPkg::fifoStatT   fifoStat_o
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);

    logic [31:0]      mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wrPtr;
    logic [PTR_W-1:0] rdPtr;
    logic [PTR_W:0]   count;
    logic [1:0]       bytePtr;                 // Next byte lane, 0 is bits 31:24
    logic [23:0]      stage;                   // Upper three bytes of the word being built
    logic             flushPend;
    logic             flushDone;
    logic             startQ;
    logic             empty;
    logic             full;
    logic             padEn;
    logic             wrEn;
    logic [31:0]      wrData;

    assign empty = (count == '0);
    assign full  = (count == FIFO_DEPTH);

    // Pad a partial word only when no byte is arriving and there is room
    assign padEn  = flushPend & (bytePtr != 2'd0) & ~push_i & ~full;
    assign wrEn   = (push_i & (bytePtr == 2'd3)) | padEn;
    assign wrData = padEn ? {stage, 8'h00} : {stage, pushByte_i};

    always_ff @(posedge QnCPUCLK) begin
        if (wrEn) mem[wrPtr] <= wrData;
        if (push_i) begin
            case (bytePtr)
                2'd0:    stage <= {pushByte_i, 16'h0000};   // Clears the lanes still unused
                2'd1:    stage[15:8] <= pushByte_i;
                2'd2:    stage[7:0]  <= pushByte_i;
                default: ;
            endcase
        end
    end

    always_ff @(posedge QnCPUCLK or negedge arstN_i) begin
        if (!arstN_i) begin
            wrPtr     <= '0;
            rdPtr     <= '0;
            count     <= '0;
            bytePtr   <= 2'd0;
            flushPend <= 1'b0;
            flushDone <= 1'b0;
            startQ    <= 1'b0;
        end else begin
            startQ <= start_i;
            if (wrEn) wrPtr <= wrPtr + 1'b1;
            if (pop_i) rdPtr <= rdPtr + 1'b1;
            case ({wrEn, pop_i})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
            if (push_i) bytePtr <= bytePtr + 1'b1;
            else if (padEn) bytePtr <= 2'd0;
            // Done once nothing is staged and the queue has drained
            if (start_i & ~startQ) begin
                flushPend <= 1'b0;
                flushDone <= 1'b0;
            end else if (flush_i) begin
                flushPend <= 1'b1;
            end else if (flushPend & (bytePtr == 2'd0) & empty & ~push_i) begin
                flushPend <= 1'b0;
                flushDone <= 1'b1;
            end
        end
    end

    assign head_o = mem[rdPtr];

    // At depth 16 a full queue reads level 0, the full bit tells them apart
    assign fifoStat_o = '{empty: empty, full: full, flushDone: flushDone, level: 4'(count)};

endmodule

`default_nettype wire

/* verilog/sdmacRegisters.sv */
// SDMAC register block: CPU access decode, DMA start/stop/flush control and interrupt
`timescale 1ns/10ps
`default_nettype none

module sdmacRegisters (
    input  wire                  QnCPUCLK,
    input  wire                  arstN_i,
    input  wire sdmacPkg::cpuReqT   cpuReq_i,
    input  wire sdmacPkg::fifoStatT fifoStat_i,
    input  wire                  scsiIntReq_i,
    output sdmacPkg::dmaCtrlT    dmaCtrl_o,
    output logic [31:0]          rdata_o,
    output logic                 regAck_o,
    output logic                 intN_o
);
    import sdmacPkg::*;

    logic        intEna;
    logic [31:0] acr;
    logic        wrStrobe;
    logic        rdStrobe;
    logic        intPend;
    logic [31:0] contrRd;
    logic [31:0] istr;
    logic [31:0] rdMux;

    assign wrStrobe = cpuReq_i.valid & cpuReq_i.write;
    assign rdStrobe = cpuReq_i.valid & ~cpuReq_i.write;

    // Pending regardless of the enable, only the pin is masked
    assign intPend = scsiIntReq_i | fifoStat_i.flushDone;
    assign intN_o  = ~(intEna & intPend);

    always_comb begin
        contrRd               = '0;
        contrRd[CONTR_DMAENA] = dmaCtrl_o.dmaEna;
        contrRd[CONTR_INTENA] = intEna;
    end

    // Live status, nothing here is stored
    always_comb begin
        istr             = '0;
        istr[ISTR_INT]   = intPend;
        istr[ISTR_FE]    = fifoStat_i.flushDone;
        istr[ISTR_EMPTY] = fifoStat_i.empty;
        istr[ISTR_FULL]  = fifoStat_i.full;
        istr[ISTR_SCSI]  = scsiIntReq_i;
        istr[11:8]       = fifoStat_i.level;   // Fill level for debug
    end

    always_comb begin
        case (cpuReq_i.addr)
            ADDR_CONTR: rdMux = contrRd;
            ADDR_ACR:   rdMux = acr;
            ADDR_ISTR:  rdMux = istr;
            default:    rdMux = '0;             // Strobe addresses read as zero
        endcase
    end

    always_ff @(posedge QnCPUCLK or negedge arstN_i) begin
        if (!arstN_i) begin
            intEna    <= 1'b0;
            acr       <= '0;
            dmaCtrl_o <= '0;
        end else begin
            dmaCtrl_o.flushReq <= 1'b0;
            if (wrStrobe) begin
                case (cpuReq_i.addr)
                    ADDR_CONTR: intEna <= cpuReq_i.wdata[CONTR_INTENA];
                    ADDR_ACR:   acr    <= cpuReq_i.wdata;
                    ADDR_STDMA: begin
                        dmaCtrl_o.dmaEna    <= 1'b1;
                        dmaCtrl_o.startAddr <= acr;   // Counter starts from ACR
                    end
                    ADDR_SPDMA: dmaCtrl_o.dmaEna   <= 1'b0;
                    ADDR_FLUSH: dmaCtrl_o.flushReq <= 1'b1;
                    default: ;
                endcase
            end
        end
    end

    // Ack and read data one cycle after the strobe
    always_ff @(posedge QnCPUCLK or negedge arstN_i) begin
        if (!arstN_i) begin
            regAck_o <= 1'b0;
            rdata_o  <= '0;
        end else begin
            regAck_o <= cpuReq_i.valid;
            if (rdStrobe) rdata_o <= rdMux;
        end
    end

endmodule

`default_nettype wire

/* verilog/sdmacPkg.sv */
// SDMAC shared definitions: register map, state encodings and block interfaces
`default_nettype none

package sdmacPkg;

    localparam int ADDR_W = 32;         // Host bus address width

    // Bit positions inside CONTR
    localparam int CONTR_DMAENA = 0;    // Read only, follows start/stop
    localparam int CONTR_INTENA = 2;

    // Bit positions inside ISTR
    localparam int ISTR_INT   = 0;
    localparam int ISTR_FE    = 1;      // Flush done
    localparam int ISTR_EMPTY = 2;
    localparam int ISTR_FULL  = 3;
    localparam int ISTR_SCSI  = 4;

    // CPU register map, taken from address bits 6:2
    typedef enum logic [4:0] {
        ADDR_CONTR = 5'h02,
        ADDR_ACR   = 5'h03,
        ADDR_STDMA = 5'h04,             // Write strobe only
        ADDR_FLUSH = 5'h05,             // Write strobe only
        ADDR_ISTR  = 5'h07,
        ADDR_SPDMA = 5'h0F              // Write strobe only
    } regAddrT;

    typedef struct packed {
        logic        valid;
        logic        write;
        regAddrT     addr;
        logic [31:0] wdata;
    } cpuReqT;

    typedef struct packed {
        logic              dmaEna;
        logic              flushReq;    // One cycle pulse
        logic [ADDR_W-1:0] startAddr;
    } dmaCtrlT;

    typedef struct packed {
        logic       empty;
        logic       full;
        logic       flushDone;
        logic [3:0] level;              // Longwords queued
    } fifoStatT;

    typedef enum logic [1:0] {
        SCSI_IDLE,
        SCSI_STROBE1,
        SCSI_STROBE2,
        SCSI_LATCH
    } scsiStateT;

    typedef enum logic [2:0] {
        CPU_IDLE,
        CPU_REQUEST,
        CPU_OWN,
        CPU_STROBE,
        CPU_RELEASE
    } cpuStateT;

endpackage

`default_nettype wire
